//--- verilog/aes_config.svh
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// ************************************************************
// block geometry
// ************************************************************
`define AES_BLOCK_W 128    // state and key width
`define AES_SLICE_W 16     // bits substituted per clock, two s-boxes
`define AES_SLICES  8      // slices per state word, one round = 8 clocks

// ************************************************************
// cipher constants
// ************************************************************
`define AES_ROUNDS  10     // aes-128 round count

// low byte of x^8 + x^4 + x^3 + x + 1, used by xtime
`define AES_POLY    8'h1B

`endif

//--- verilog/aes_pkg.sv
`include "aes_config.svh"

package aes_pkg;

   // ************************************************************
   // state word
   // ************************************************************
   // same 128 bits seen two ways
   //   slice  : serial s-box view, slice 0 is the top 16 bits
   //   col    : column view for shiftrows / mixcolumns, col 0 on top
   typedef union packed {
      logic [0:`AES_SLICES-1][`AES_SLICE_W-1:0] slice;
      logic [0:`AES_BLOCK_W/32-1][31:0]         col;
   } aes_block_u;

   // one-hot slice pointer, bit i selects slice i
   typedef logic [`AES_SLICES-1:0] slice_sel_t;

   // ************************************************************
   // per-cycle step flags from the round controller
   // ************************************************************
   typedef struct packed {
      logic step;       // a slice goes through the s-boxes this cycle
      logic round_end;  // eighth slice, state and round key update
      logic final_rnd;  // last round, no mixcolumns
   } aes_step_s;

endpackage

//--- verilog/aes_sbox.sv
module aes_sbox (
   input  logic [7:0] x,
   output logic [7:0] s
);

   localparam logic [3:0] LAMBDA = 4'hC;  // x^2 + x + lambda over gf(16)
   localparam logic [7:0] AFFINE_C = 8'h63;

   logic [7:0] q;            // input in tower basis
   logic [3:0] d;            // gf(16) norm of the byte
   logic [3:0] d_inv;
   logic [7:0] inv_t;        // inverse, tower basis
   logic [7:0] inv;          // inverse, polynomial basis

   // ************************************************************
   // gf(4) and gf(16) arithmetic, gf(((2^2)^2)^2)
   // ************************************************************
   function automatic logic [1:0] gf4_mul(input logic [1:0] a, input logic [1:0] b);
      logic hh;
      hh = a[1] & b[1];
      return {hh ^ (a[1] & b[0]) ^ (a[0] & b[1]), hh ^ (a[0] & b[0])};
   endfunction

   function automatic logic [1:0] gf4_sq(input logic [1:0] a);
      return {a[1], a[1] ^ a[0]};  // also the gf(4) inverse
   endfunction

   function automatic logic [1:0] gf4_phi(input logic [1:0] a);
      return {a[1] ^ a[0], a[1]};  // times phi = {10}
   endfunction

   function automatic logic [3:0] gf16_mul(input logic [3:0] a, input logic [3:0] b);
      logic [1:0] hh;
      hh = gf4_mul(a[3:2], b[3:2]);
      return {hh ^ gf4_mul(a[3:2], b[1:0]) ^ gf4_mul(a[1:0], b[3:2]),
              gf4_phi(hh) ^ gf4_mul(a[1:0], b[1:0])};
   endfunction

   function automatic logic [3:0] gf16_inv(input logic [3:0] a);
      logic [1:0] e;
      e = gf4_sq(gf4_phi(gf4_sq(a[3:2])) ^ gf4_mul(a[3:2], a[1:0]) ^ gf4_sq(a[1:0]));
      return {gf4_mul(a[3:2], e), gf4_mul(a[3:2] ^ a[1:0], e)};
   endfunction

   always_comb begin
      // map into tower basis
      q[7] = x[7] ^ x[5];
      q[6] = x[7] ^ x[6] ^ x[4] ^ x[3] ^ x[2] ^ x[1];
      q[5] = x[7] ^ x[5] ^ x[3] ^ x[2];
      q[4] = x[7] ^ x[5] ^ x[3] ^ x[2] ^ x[1];
      q[3] = x[7] ^ x[6] ^ x[2] ^ x[1];
      q[2] = x[7] ^ x[4] ^ x[3] ^ x[2] ^ x[1];
      q[1] = x[6] ^ x[4] ^ x[1];
      q[0] = x[6] ^ x[1] ^ x[0];
      // norm, then invert in gf(16)
      d = gf16_mul(gf16_mul(q[7:4], q[7:4]), LAMBDA) ^ gf16_mul(q[7:4], q[3:0])
          ^ gf16_mul(q[3:0], q[3:0]);
      d_inv = gf16_inv(d);                      // zero maps to zero
      inv_t = {gf16_mul(q[7:4], d_inv), gf16_mul(q[7:4] ^ q[3:0], d_inv)};
      // back to polynomial basis
      inv[7] = inv_t[7] ^ inv_t[6] ^ inv_t[5] ^ inv_t[1];
      inv[6] = inv_t[6] ^ inv_t[2];
      inv[5] = inv_t[6] ^ inv_t[5] ^ inv_t[1];
      inv[4] = inv_t[6] ^ inv_t[5] ^ inv_t[4] ^ inv_t[2] ^ inv_t[1];
      inv[3] = inv_t[5] ^ inv_t[4] ^ inv_t[3] ^ inv_t[2] ^ inv_t[1];
      inv[2] = inv_t[7] ^ inv_t[4] ^ inv_t[3] ^ inv_t[2] ^ inv_t[1];
      inv[1] = inv_t[5] ^ inv_t[4];
      inv[0] = inv_t[6] ^ inv_t[5] ^ inv_t[4] ^ inv_t[2] ^ inv_t[0];
      // affine output map, circulant 1f
      s = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
          ^ {inv[3:0], inv[7:4]} ^ AFFINE_C;
   end

endmodule

//--- verilog/aes_mix_column.sv
`include "aes_config.svh"

module aes_mix_column (
   input  logic [31:0] col,
   output logic [31:0] mixed
);

   logic [7:0] a [0:3];   // column bytes, row 0 on top
   logic [7:0] b [0:3];   // doubled bytes

   // multiply by {02} in gf(2^8)
   function automatic logic [7:0] xtime(input logic [7:0] v);
      return {v[6:0], 1'b0} ^ (v[7] ? `AES_POLY : 8'h00);
   endfunction

   always_comb begin
      for (int r = 0; r < 4; r++) begin
         a[r] = col[31-8*r -: 8];
         b[r] = xtime(a[r]);
      end
      // rows of the 2 3 1 1 circulant, 3a = 2a ^ a
      mixed[31:24] = b[0] ^ a[1] ^ b[1] ^ a[2] ^ a[3];
      mixed[23:16] = a[0] ^ b[1] ^ a[2] ^ b[2] ^ a[3];
      mixed[15:8]  = a[0] ^ a[1] ^ b[2] ^ a[3] ^ b[3];
      mixed[7:0]   = a[0] ^ b[0] ^ a[1] ^ a[2] ^ b[3];
   end

endmodule

//--- verilog/aes_key_sched.sv
`include "aes_config.svh"

module aes_key_sched (
   input  logic                CLK,
   input  logic                rst,
   input  logic                en,
   input  aes_pkg::aes_block_u kin,
   input  logic                krdy,
   input  logic                drdy,
   input  aes_pkg::aes_step_s  step,
   input  logic [7:0]          rcon,
   output aes_pkg::aes_block_u cipher_key,
   output aes_pkg::aes_block_u round_key
);
   import aes_pkg::*;

   aes_block_u  key_reg;           // stored cipher key
   aes_block_u  rkey_reg;          // key of the round just finished
   aes_block_u  rkey_next;
   logic [31:0] rot_word;          // rotword of the last column
   logic [7:0]  sub_bytes [0:3];

   // ************************************************************
   // one expansion step, four s-boxes on the rotated last word
   // ************************************************************
   assign rot_word = {rkey_reg.col[3][23:0], rkey_reg.col[3][31:24]};

   for (genvar b = 0; b < 4; b++) begin : g_sbox
      aes_sbox u_sbox (
         .x (rot_word[31-8*b -: 8]),
         .s (sub_bytes[b])
      );
   end

   always_comb begin
      rkey_next.col[0] = rkey_reg.col[0]
                         ^ {sub_bytes[0] ^ rcon, sub_bytes[1], sub_bytes[2], sub_bytes[3]};
      for (int c = 1; c < 4; c++) begin
         rkey_next.col[c] = rkey_next.col[c-1] ^ rkey_reg.col[c];  // word chain
      end
   end

   assign round_key  = rkey_next;  // addroundkey of the running round
   assign cipher_key = key_reg;

   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         key_reg  <= '0;
         rkey_reg <= '0;
      end else if (en) begin
         if (krdy) begin
            key_reg  <= kin;
            rkey_reg <= kin;
         end else if (drdy) begin
            rkey_reg <= key_reg;       // every block restarts from round 0
         end else if (step.round_end) begin
            rkey_reg <= rkey_next;
         end
      end
   end

endmodule

//--- verilog/aes_datapath.sv
`include "aes_config.svh"

module aes_datapath (
   input  logic                CLK,
   input  logic                rst,
   input  logic                en,
   input  aes_pkg::aes_block_u din,
   input  logic                drdy,
   input  aes_pkg::aes_block_u cipher_key,
   input  aes_pkg::aes_block_u round_key,
   input  aes_pkg::slice_sel_t slice_sel,
   input  aes_pkg::aes_step_s  step,
   output aes_pkg::aes_block_u dout
);
   import aes_pkg::*;

   aes_block_u state;                                    // cipher state
   logic [0:`AES_SLICES-2][`AES_SLICE_W-1:0] slice_buf;  // substituted slices 0..6
   logic [`AES_SLICE_W-1:0] cur_slice;                   // slice under substitution
   logic [`AES_SLICE_W-1:0] sub_slice;
   aes_block_u  joined;                                  // full subbytes result
   aes_block_u  shifted;                                 // after shiftrows
   aes_block_u  mixed;                                   // after optional mixcolumns
   aes_block_u  next_state;
   logic [31:0] mix_cols [0:3];

   // ************************************************************
   // serial subbytes, one 16-bit slice per clock
   // ************************************************************
   always_comb begin
      cur_slice = '0;
      for (int i = 0; i < `AES_SLICES; i++) begin
         cur_slice |= state.slice[i] & {`AES_SLICE_W{slice_sel[i]}};  // one-hot and-or mux
      end
   end

   aes_sbox u_sbox_hi (
      .x (cur_slice[15:8]),
      .s (sub_slice[15:8])
   );

   aes_sbox u_sbox_lo (
      .x (cur_slice[7:0]),
      .s (sub_slice[7:0])
   );

   always_ff @(posedge CLK) begin
      if (en && step.step) begin
         for (int i = 0; i < `AES_SLICES-1; i++) begin
            if (slice_sel[i]) begin
               slice_buf[i] <= sub_slice;
            end
         end
      end
   end

   // ************************************************************
   // round end: shiftrows, mixcolumns, addroundkey
   // ************************************************************
   always_comb begin
      joined = {slice_buf, sub_slice};   // last slice goes straight in
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            shifted.col[c][31-8*r -: 8] = joined.col[(c+r)%4][31-8*r -: 8];  // row r left by r
         end
      end
   end

   for (genvar c = 0; c < 4; c++) begin : g_mix
      aes_mix_column u_mix (
         .col   (shifted.col[c]),
         .mixed (mix_cols[c])
      );
   end

   always_comb begin
      for (int c = 0; c < 4; c++) begin
         mixed.col[c] = step.final_rnd ? shifted.col[c] : mix_cols[c];
      end
      next_state = mixed ^ round_key;
   end

   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         state <= '0;
      end else if (en) begin
         if (drdy) begin
            state <= din ^ cipher_key;   // initial key addition
         end else if (step.round_end) begin
            state <= next_state;
         end
      end
   end

   assign dout = state;   // holds the ciphertext until the next drdy

endmodule

//--- verilog/aes_round_ctrl.sv
`include "aes_config.svh"

module aes_round_ctrl (
   input  logic                CLK,
   input  logic                rst,
   input  logic                en,
   input  logic                krdy,
   input  logic                drdy,
   output aes_pkg::slice_sel_t slice_sel,
   output aes_pkg::aes_step_s  step,
   output logic [7:0]          rcon,
   output logic                kvld,
   output logic                dvld,
   output logic                busy
);
   import aes_pkg::*;

   logic [3:0] round;   // current round, 1..10
   logic       done;    // last round stored, dvld next edge

   // ************************************************************
   // slice / round sequencing
   // ************************************************************
   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         slice_sel <= '0;
         step      <= '0;
         round     <= '0;
         rcon      <= 8'h01;
         done      <= 1'b0;
         kvld      <= 1'b0;
         dvld      <= 1'b0;
         busy      <= 1'b0;
      end else if (en) begin
         kvld <= krdy;                      // key taken on this edge
         dvld <= done & ~drdy;              // restart swallows the pulse
         busy <= drdy | step.step | done;
         if (drdy) begin
            slice_sel      <= slice_sel_t'(1);   // slice 0 first
            round          <= 4'd1;
            rcon           <= 8'h01;
            done           <= 1'b0;
            step.step      <= 1'b1;
            step.round_end <= 1'b0;
            step.final_rnd <= 1'b0;
         end else if (step.step) begin
            slice_sel      <= {slice_sel[`AES_SLICES-2:0], slice_sel[`AES_SLICES-1]};
            step.round_end <= slice_sel[`AES_SLICES-2];   // next slice is the last one
            if (step.round_end) begin
               round          <= round + 4'd1;
               rcon           <= {rcon[6:0], 1'b0} ^ (rcon[7] ? `AES_POLY : 8'h00);
               step.final_rnd <= (round == 4'(`AES_ROUNDS - 1));
               if (step.final_rnd) begin
                  step.step <= 1'b0;        // ciphertext now in the state
                  done      <= 1'b1;
               end
            end
         end else begin
            done <= 1'b0;
         end
      end
   end

endmodule

//--- verilog/aes_enc_top.sv
`include "aes_config.svh"

module aes_enc_top (
   input  logic                    CLK,
   input  logic                    rst,
   input  logic                    en,
   input  logic [`AES_BLOCK_W-1:0] kin,
   input  logic                    krdy,
   input  logic [`AES_BLOCK_W-1:0] din,
   input  logic                    drdy,
   output logic [`AES_BLOCK_W-1:0] dout,
   output logic                    kvld,
   output logic                    dvld,
   output logic                    busy
);
   import aes_pkg::*;

   aes_block_u cipher_key;   // stored key, for the load xor
   aes_block_u round_key;    // key of the running round
   aes_block_u state_out;
   slice_sel_t slice_sel;
   aes_step_s  step;
   logic [7:0] rcon;

   // ************************************************************
   // control, key schedule, data path
   // ************************************************************
   aes_round_ctrl u_ctrl (
      .CLK       (CLK),
      .rst       (rst),
      .en        (en),
      .krdy      (krdy),
      .drdy      (drdy),
      .slice_sel (slice_sel),
      .step      (step),
      .rcon      (rcon),
      .kvld      (kvld),
      .dvld      (dvld),
      .busy      (busy)
   );

   aes_key_sched u_key (
      .CLK        (CLK),
      .rst        (rst),
      .en         (en),
      .kin        (kin),
      .krdy       (krdy),
      .drdy       (drdy),
      .step       (step),
      .rcon       (rcon),
      .cipher_key (cipher_key),
      .round_key  (round_key)
   );

   aes_datapath u_data (
      .CLK        (CLK),
      .rst        (rst),
      .en         (en),
      .din        (din),
      .drdy       (drdy),
      .cipher_key (cipher_key),
      .round_key  (round_key),
      .slice_sel  (slice_sel),
      .step       (step),
      .dout       (state_out)
   );

   assign dout = state_out;

endmodule

//--- testbench/aes_enc_chk.sv
module aes_enc_chk (
   input logic CLK,
   input logic rst,
   input logic en,
   input logic drdy,
   input logic kvld,
   input logic dvld,
   input logic busy
);
   timeunit 1ns;
   timeprecision 100ps;

   // ************************************************************
   // status flag protocol
   // ************************************************************
   // pulses last one enabled edge, frozen cycles don't count
   a_dvld_pulse : assert property (@(posedge CLK) disable iff (rst) (dvld && en) |=> !dvld)
      else $error("dvld stayed high across an enabled edge");

   a_kvld_pulse : assert property (@(posedge CLK) disable iff (rst) (kvld && en) |=> !kvld)
      else $error("kvld stayed high across an enabled edge");

   // busy ends with the dvld pulse unless a new block starts on that edge
   a_dvld_busy : assert property (@(posedge CLK) disable iff (rst)
      (dvld && en && !drdy) |=> !busy)
      else $error("busy still high after the dvld pulse");

   // first edge after reset release, flags still at reset value
   a_reset_quiet : assert property (@(posedge CLK) $fell(rst) |-> !kvld && !dvld && !busy)
      else $error("status flag high right after reset");

endmodule

bind aes_enc_top aes_enc_chk u_chk (
   .CLK  (CLK),
   .rst  (rst),
   .en   (en),
   .drdy (drdy),
   .kvld (kvld),
   .dvld (dvld),
   .busy (busy)
);

//--- testbench/aes_enc_tb.sv
`include "aes_config.svh"

module aes_enc_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_RANDOM    = 40;
   localparam int N_SAME_KEY  = 5;
   localparam int N_GAPPED    = 8;
   localparam int N_RESTART   = 4;
   localparam int MAX_GAP     = 60;    // disabled cycles allowed per gapped block
   localparam int LATENCY     = 81;    // enabled edges from drdy edge to dvld
   localparam int BLOCK_LIMIT = LATENCY + MAX_GAP + 20;
   localparam int N_BLOCKS    = 1 + N_RANDOM + N_SAME_KEY + N_GAPPED + 2 * N_RESTART;
   localparam longint WATCHDOG_NS = (N_BLOCKS * 90 + N_GAPPED * MAX_GAP + 200) * 100;

   logic                    CLK, rst, en, krdy, drdy;
   logic [`AES_BLOCK_W-1:0] kin, din, dout;
   logic                    kvld, dvld, busy;
   int errors, test_errs, tests_passed, tests_failed, test_num;
   logic [127:0] key, pt, pt_b;

   aes_enc_top DUT (
      .CLK (CLK), .rst (rst), .en (en),
      .kin (kin), .krdy (krdy), .din (din), .drdy (drdy),
      .dout (dout), .kvld (kvld), .dvld (dvld), .busy (busy)
   );

   always #50 CLK = ~CLK;   // 100 ns period

   // ************************************************************
   // reference model, plain byte-array aes-128
   // ************************************************************
   function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] p;
      logic [7:0] aa;
      p  = '0;
      aa = a;
      for (int i = 0; i < 8; i++) begin
         if (b[i]) p ^= aa;
         aa = {aa[6:0], 1'b0} ^ (aa[7] ? `AES_POLY : 8'h00);
      end
      return p;
   endfunction

   function automatic logic [7:0] sbox_ref(input logic [7:0] x);
      logic [7:0] inv;
      logic [7:0] pw;
      logic [7:0] s;
      inv = 8'h01;
      pw  = x;
      for (int i = 0; i < 8; i++) begin   // x^254 by square and multiply
         if (8'hFE >> i & 1) inv = gf_mul(inv, pw);
         pw = gf_mul(pw, pw);
      end
      for (int i = 0; i < 8; i++) begin
         s[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
      end
      return s ^ 8'h63;
   endfunction

   function automatic logic [127:0] aes_ref(input logic [127:0] k, input logic [127:0] p);
      logic [7:0] st [0:15];   // byte 4c+r is row r, column c
      logic [7:0] sb [0:15];
      logic [7:0] rk [0:15];
      logic [7:0] t [0:3];
      logic [7:0] a [0:3];
      logic [7:0] rc;
      logic [127:0] ct;
      rc = 8'h01;
      for (int i = 0; i < 16; i++) begin
         rk[i] = k[127-8*i -: 8];
         st[i] = p[127-8*i -: 8] ^ rk[i];
      end
      for (int rnd = 1; rnd <= `AES_ROUNDS; rnd++) begin
         t[0] = sbox_ref(rk[13]) ^ rc;   // subword(rotword(w3)) ^ rcon
         t[1] = sbox_ref(rk[14]);
         t[2] = sbox_ref(rk[15]);
         t[3] = sbox_ref(rk[12]);
         for (int i = 0; i < 16; i++) begin
            if (i < 4) rk[i] ^= t[i];
            else rk[i] ^= rk[i-4];
         end
         rc = gf_mul(rc, 8'h02);
         for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
               sb[4*c+r] = sbox_ref(st[4*((c+r)%4)+r]);   // subbytes + shiftrows
            end
         end
         for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) a[r] = sb[4*c+r];
            if (rnd < `AES_ROUNDS) begin
               st[4*c]   = gf_mul(a[0], 2) ^ gf_mul(a[1], 3) ^ a[2] ^ a[3];
               st[4*c+1] = a[0] ^ gf_mul(a[1], 2) ^ gf_mul(a[2], 3) ^ a[3];
               st[4*c+2] = a[0] ^ a[1] ^ gf_mul(a[2], 2) ^ gf_mul(a[3], 3);
               st[4*c+3] = gf_mul(a[0], 3) ^ a[1] ^ a[2] ^ gf_mul(a[3], 2);
            end else begin
               for (int r = 0; r < 4; r++) st[4*c+r] = a[r];
            end
         end
         for (int i = 0; i < 16; i++) st[i] ^= rk[i];
      end
      for (int i = 0; i < 16; i++) ct[127-8*i -: 8] = st[i];
      return ct;
   endfunction

   // ************************************************************
   // checks and stimulus helpers
   // ************************************************************
   task automatic compare(input string what, input logic [127:0] got, input logic [127:0] exp);
      if (got !== exp) begin
         $display("[FAIL] t=%0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic next_cycle();   // edge, then the drive point
      @(posedge CLK);
      #10;
   endtask

   task automatic begin_test();
      test_num++;
      test_errs = errors;
   endtask

   task automatic finish_test(input string name);
      if (errors == test_errs) tests_passed++;
      else tests_failed++;
      $display("test %0d %s: %s", test_num, name, (errors == test_errs) ? "ok" : "FAILED");
   endtask

   task automatic load_key(input logic [127:0] k);
      kin  = k;
      krdy = 1'b1;
      en   = 1'b1;
      next_cycle();
      krdy = 1'b0;
      compare("kvld after krdy", kvld, 1);
      next_cycle();
      compare("kvld second cycle", kvld, 0);
   endtask

   // start a block and wait for dvld, optional random en gaps
   task automatic run_block(input logic [127:0] p, input logic [127:0] exp, input bit gaps);
      int  edges;
      int  waited;
      int  gap_left;
      int  disabled;
      bit  seen;
      logic en_now;
      edges    = 0;
      waited   = 0;
      gap_left = 0;
      disabled = 0;
      seen     = 0;
      din  = p;
      drdy = 1'b1;
      en   = 1'b1;
      next_cycle();
      drdy = 1'b0;
      while (!seen && waited < BLOCK_LIMIT) begin
         compare("busy during block", busy, 1);
         en_now = 1'b1;
         if (gaps) begin
            if (gap_left == 0 && disabled < MAX_GAP && $urandom_range(0, 9) == 0)
               gap_left = $urandom_range(1, 6);
            if (gap_left > 0) begin
               en_now = 1'b0;
               gap_left--;
               disabled++;
            end
         end
         en = en_now;
         next_cycle();
         waited++;
         if (en_now) edges++;
         seen = dvld;
      end
      en = 1'b1;
      if (!seen) begin
         $display("block never finished, no dvld within %0d cycles", BLOCK_LIMIT);
         errors++;
      end else begin
         compare("enabled edges to dvld", edges, LATENCY);
         compare("busy with dvld", busy, 1);
         compare("ciphertext", dout, exp);
         next_cycle();
         compare("dvld after pulse", dvld, 0);
         compare("busy after pulse", busy, 0);
      end
   endtask

   // ************************************************************
   // watchdog
   // ************************************************************
   initial begin
      #(WATCHDOG_NS);
      $display("timeout, the run did not finish in %0d ns", WATCHDOG_NS);
      $display("Regression failed");
      $finish;
   end

   // ************************************************************
   // test sequence
   // ************************************************************
   initial begin
      CLK  = 1'b0;
      rst  = 1'b1;
      en   = 1'b0;
      kin  = '0;
      krdy = 1'b0;
      din  = '0;
      drdy = 1'b0;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      test_num     = 0;
      void'($urandom(34075));
      repeat (2) @(posedge CLK);
      #10 rst = 1'b0;
      en = 1'b1;

      begin_test();
      repeat (4) begin
         compare("kvld after reset", kvld, 0);
         compare("dvld after reset", dvld, 0);
         compare("busy after reset", busy, 0);
         next_cycle();
      end
      finish_test("reset flags");

      begin_test();
      key = 128'h000102030405060708090a0b0c0d0e0f;
      pt  = 128'h00112233445566778899aabbccddeeff;
      compare("model vs known answer", aes_ref(key, pt), 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
      load_key(key);
      run_block(pt, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 0);
      finish_test("known answer");

      begin_test();
      repeat (N_RANDOM) begin
         key = {$urandom, $urandom, $urandom, $urandom};
         pt  = {$urandom, $urandom, $urandom, $urandom};
         load_key(key);
         run_block(pt, aes_ref(key, pt), 0);
      end
      finish_test("random keys");

      begin_test();
      key = {$urandom, $urandom, $urandom, $urandom};
      load_key(key);
      repeat (N_SAME_KEY) begin   // round key must come back from the stored key
         pt = {$urandom, $urandom, $urandom, $urandom};
         run_block(pt, aes_ref(key, pt), 0);
      end
      finish_test("same key");

      begin_test();
      repeat (N_GAPPED) begin
         key = {$urandom, $urandom, $urandom, $urandom};
         pt  = {$urandom, $urandom, $urandom, $urandom};
         load_key(key);
         run_block(pt, aes_ref(key, pt), 1);
      end
      finish_test("enable gaps");

      begin_test();
      repeat (N_RESTART) begin
         key  = {$urandom, $urandom, $urandom, $urandom};
         pt   = {$urandom, $urandom, $urandom, $urandom};
         pt_b = {$urandom, $urandom, $urandom, $urandom};
         load_key(key);
         din  = pt;
         drdy = 1'b1;
         next_cycle();
         drdy = 1'b0;
         repeat ($urandom_range(10, 75)) begin   // abandon somewhere mid-block
            next_cycle();
            compare("dvld of abandoned block", dvld, 0);
         end
         run_block(pt_b, aes_ref(key, pt_b), 0);
      end
      finish_test("restart");

      $display("tests passed %0d, tests failed %0d, check errors %0d",
               tests_passed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+verilog
verilog/aes_pkg.sv
verilog/aes_sbox.sv
verilog/aes_mix_column.sv
verilog/aes_key_sched.sv
verilog/aes_datapath.sv
verilog/aes_round_ctrl.sv
verilog/aes_enc_top.sv
testbench/aes_enc_chk.sv
testbench/aes_enc_tb.sv
